// ==== risc8.f ====
+incdir+.
risc8_pkg.sv
risc8_alu.sv
risc8_regfile.sv
risc8_decode.sv
risc8_execute.sv
risc8_core.sv
tb_risc8_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the risc8 core with its testbench and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_risc8_core \
	-f risc8.f -o risc8_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/risc8_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended early"; exit 1; }
exit 0

// ==== tb_risc8_model.svh ====
`ifndef TB_RISC8_MODEL_SVH
`define TB_RISC8_MODEL_SVH

// program rom, one word per address
logic [15:0] rom [256];
int prog_len;

// expected OUT writes as {data address, data byte}
logic [23:0] expected_writes [$];

// instruction level state of the reference model
logic [7:0] model_regs [32];
logic model_c;
logic model_z;

// two register form, Rr split over bit 9 and bits 3:0
function automatic logic [15:0] enc_rr(input logic [5:0] op, input logic [4:0] d,
		input logic [4:0] r);
	return {op, r[4], d, r[3:0]};
endfunction

// immediate form, only r16 to r31 can be named
function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [4:0] d,
		input logic [7:0] k);
	return {op, k[7:4], d[3:0], k[3:0]};
endfunction

// COM, INC and DEC differ in the low nibble
function automatic logic [15:0] enc_one(input logic [3:0] sub, input logic [4:0] d);
	return {7'b1001010, d, sub};
endfunction

function automatic logic [15:0] enc_out(input logic [5:0] a, input logic [4:0] d);
	return {5'b10111, a[5:4], d, a[3:0]};
endfunction

function automatic logic [15:0] enc_rjmp(input logic [11:0] k);
	return {4'b1100, k};
endfunction

// clear set means BRBC
function automatic logic [15:0] enc_branch(input logic clear, input logic [2:0] s,
		input logic [6:0] k);
	return {5'b11110, clear, k, s};
endfunction

task automatic clear_program();
	// unknown opcodes with the address in the low byte
	for (int i = 0; i < 256; i++)
		rom[i] = {8'h00, 8'(i)};
	prog_len = 0;
	expected_writes.delete();
endtask

task automatic emit(input logic [15:0] word);
	rom[prog_len] = word;
	prog_len++;
endtask

// add or subtract with optional carry in
task automatic model_arith(input logic subtract, input logic [7:0] x, input logic [7:0] y,
		input logic chain, input logic write, input logic [4:0] dst);
	int value;
	value = subtract ? int'(x) - int'(y) : int'(x) + int'(y);
	if (chain)
		value = subtract ? value - int'(model_c) : value + int'(model_c);
	// borrow goes below zero, carry goes above 255
	model_c = subtract ? (value < 0) : (value > 255);
	// chained forms only keep Z when every byte was zero
	model_z = (value[7:0] == 8'h00) && (model_z || !chain);
	if (write)
		model_regs[dst] = value[7:0];
endtask

// logic ops, COM, INC and DEC touch Z only
task automatic model_result(input logic [7:0] value, input logic [4:0] dst);
	model_regs[dst] = value;
	model_z = (value == 8'h00);
endtask

// runs the rom from address 0 until the jump to itself
task automatic run_model();
	int pc_m;
	int next;
	int steps;
	logic [15:0] w;
	logic [7:0] ra;
	logic [7:0] rb;
	logic [7:0] rh;
	logic [7:0] k;
	logic [4:0] hi;
	logic flag;
	bit done;
	for (int i = 0; i < 32; i++)
		model_regs[i] = 8'h00;
	model_c = 1'b0;
	model_z = 1'b0;
	pc_m = 0;
	steps = 0;
	done = 1'b0;
	while (!done && steps < 1000) begin
		w = rom[pc_m];
		ra = model_regs[w[8:4]];
		rb = model_regs[{w[9], w[3:0]}];
		hi = {1'b1, w[7:4]};
		rh = model_regs[hi];
		k = {w[11:8], w[3:0]};
		next = pc_m + 1;
		casez (w[15:10])
		// CPC, SBC, CP and SUB
		6'b000001, 6'b000010, 6'b000101, 6'b000110:
			model_arith(1'b1, ra, rb, !w[12], w[11], w[8:4]);
		// ADD and ADC
		6'b000011, 6'b000111:
			model_arith(1'b0, ra, rb, w[12], 1'b1, w[8:4]);
		6'b001000: model_result(ra & rb, w[8:4]);
		6'b001001: model_result(ra ^ rb, w[8:4]);
		6'b001010: model_result(ra | rb, w[8:4]);
		6'b001011: model_regs[w[8:4]] = rb;
		6'b0011??: model_arith(1'b1, rh, k, 1'b0, 1'b0, hi);
		6'b0100??: model_arith(1'b1, rh, k, 1'b1, 1'b1, hi);
		6'b0101??: model_arith(1'b1, rh, k, 1'b0, 1'b1, hi);
		6'b0110??: model_result(rh | k, hi);
		6'b0111??: model_result(rh & k, hi);
		6'b100101: begin
			if (w[3:0] == 4'h0)
				model_result(~ra, w[8:4]);
			else if (w[3:0] == 4'h3)
				model_result(ra + 8'd1, w[8:4]);
			else if (w[3:0] == 4'ha)
				model_result(ra - 8'd1, w[8:4]);
		end
		// io address plus 0x20 on the data port
		6'b10111?: expected_writes.push_back({16'h0020 + {10'd0, w[10:9], w[3:0]}, ra});
		6'b1100??: begin
			next = pc_m + 1 + int'($signed(w[11:0]));
			done = (next == pc_m);
		end
		6'b1110??: model_regs[hi] = k;
		6'b11110?: begin
			// bits 2 to 7 of the status register read as zero
			flag = (w[2:0] == 3'd0) ? model_c : (w[2:0] == 3'd1) ? model_z : 1'b0;
			if (flag != w[10])
				next = pc_m + 1 + int'($signed(w[9:3]));
		end
		default: begin
		end
		endcase
		pc_m = next;
		steps++;
	end
endtask

`endif

// ==== tb_risc8_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_risc8_core;
	logic clk;
	logic reset;
	logic [15:0] pc;
	logic [15:0] cdata;
	logic [15:0] data_addr;
	logic data_wen;
	logic [7:0] data_write;

	integer seed;
	string test_name;
	int writes_seen;
	// reset and OUT opcode as seen at the previous edge
	logic reset_prev;
	logic out_pending;

	`include "tb_risc8_model.svh"

	risc8_core UUT (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// program memory answers one cycle after pc
	always @(posedge clk)
		cdata <= rom[pc[7:0]];

	task automatic fail_now(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// compare one write pulse with the head of the queue
	task automatic check_write();
		logic [23:0] expected;
		if (expected_writes.size() == 0) begin
			fail_now($sformatf("%s: write of %h to %h when no write was expected",
				test_name, data_write, data_addr));
		end else begin
			expected = expected_writes.pop_front();
			writes_seen++;
			assert ({data_addr, data_write} == expected)
			else fail_now($sformatf("MISMATCH %s: expected addr %h data %h, actual addr %h data %h",
				test_name, expected[23:8], expected[7:0], data_addr, data_write));
		end
	endtask

	// write port monitor sampling the values from before the edge
	always @(posedge clk) begin
		reset_prev <= reset;
		// the word right after reset is a bubble
		out_pending <= !reset && !reset_prev && (cdata[15:11] == 5'b10111);
		if (reset_prev) begin
			assert (pc == 16'h0000 && !data_wen)
			else fail_now($sformatf(
				"MISMATCH %s: expected pc 0000 data_wen 0, actual pc %h data_wen %b",
				test_name, pc, data_wen));
		end else if (!reset) begin
			assert (data_wen == out_pending)
			else fail_now($sformatf("MISMATCH %s: expected data_wen %b, actual data_wen %b",
				test_name, out_pending, data_wen));
			if (data_wen)
				check_write();
		end
	end

	// hold reset and load a fresh rom
	task automatic start_program(input string name);
		reset <= 1'b1;
		@(posedge clk);
		test_name = name;
		clear_program();
	endtask

	// run the model, release reset and wait for every expected write
	task automatic finish_program();
		int cycles;
		int target;
		run_model();
		target = writes_seen + expected_writes.size();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (writes_seen < target && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (writes_seen < target)
			fail_now($sformatf("%s: timed out waiting for OUT writes, %0d of %0d seen",
				test_name, writes_seen, target));
		else
			// a stray pulse here finds the queue empty
			repeat (20) @(posedge clk);
	endtask

	task automatic ldi_out_program();
		logic [4:0] d;
		start_program("ldi_out");
		for (int i = 0; i < 10; i++) begin
			d = {1'b1, 4'($random(seed))};
			emit(enc_imm(4'b1110, d, 8'($random(seed))));
			emit(enc_out(6'($random(seed)), d));
		end
		emit(enc_rjmp(12'hfff));
		finish_program();
	endtask

	task automatic alu_program();
		logic [4:0] d;
		logic [4:0] r;
		logic [7:0] k;
		start_program("alu_ops");
		for (int i = 16; i < 24; i++)
			emit(enc_imm(4'b1110, 5'(i), 8'($random(seed))));
		// r16 to r23 so that neighbours often depend on each other
		for (int i = 0; i < 36; i++) begin
			d = {2'b10, 3'($random(seed))};
			r = {2'b10, 3'($random(seed))};
			k = 8'($random(seed));
			case (i % 12)
			0: emit(enc_rr(6'b000011, d, r));
			1: emit(enc_rr(6'b000110, d, r));
			2: emit(enc_rr(6'b001000, d, r));
			3: emit(enc_rr(6'b001010, d, r));
			4: emit(enc_rr(6'b001001, d, r));
			5: emit(enc_rr(6'b001011, d, r));
			6: emit(enc_one(4'h0, d));
			7: emit(enc_one(4'h3, d));
			8: emit(enc_one(4'ha, d));
			9: emit(enc_imm(4'b0101, d, k));
			10: emit(enc_imm(4'b0111, d, k));
			default: emit(enc_imm(4'b0110, d, k));
			endcase
			emit(enc_out(6'(i), d));
		end
		emit(enc_rjmp(12'hfff));
		finish_program();
	endtask

	task automatic wide_program();
		start_program("wide_arith");
		for (int n = 0; n < 4; n++) begin
			for (int i = 16; i < 26; i++)
				emit(enc_imm(4'b1110, 5'(i), 8'($random(seed))));
			// r17:r16 plus r19:r18
			emit(enc_rr(6'b000011, 5'd16, 5'd18));
			emit(enc_rr(6'b000111, 5'd17, 5'd19));
			// r21:r20 minus r23:r22
			emit(enc_rr(6'b000110, 5'd20, 5'd22));
			emit(enc_rr(6'b000010, 5'd21, 5'd23));
			// r25:r24 minus a constant
			emit(enc_imm(4'b0101, 5'd24, 8'($random(seed))));
			emit(enc_imm(4'b0100, 5'd25, 8'($random(seed))));
			// compare pair must leave r19:r18 as loaded
			emit(enc_rr(6'b000101, 5'd18, 5'd22));
			emit(enc_rr(6'b000001, 5'd19, 5'd23));
			for (int i = 16; i < 26; i++)
				emit(enc_out(6'(i), 5'(i)));
		end
		emit(enc_rjmp(12'hfff));
		finish_program();
	endtask

	task automatic branch_program();
		logic [7:0] x;
		logic [7:0] y;
		logic sense;
		logic [2:0] bit_sel;
		start_program("branches");
		for (int i = 0; i < 12; i++) begin
			x = 8'($random(seed));
			// equal operands in about half the rounds
			y = ($random(seed) & 1) ? x : 8'($random(seed));
			sense = 1'($random(seed));
			bit_sel = 3'($random(seed) & 3);
			emit(enc_imm(4'b1110, 5'd16, x));
			emit(enc_imm(4'b1110, 5'd17, y));
			emit(enc_imm(4'b1110, 5'd20, 8'(8'h80 + i)));
			if (i % 2 == 0)
				emit(enc_rr(6'b000101, 5'd16, 5'd17));
			else
				emit(enc_imm(4'b0011, 5'd16, y));
			// taken branch skips the first marker
			emit(enc_branch(sense, bit_sel, 7'd1));
			emit(enc_out(6'd1, 5'd20));
			emit(enc_out(6'd2, 5'd16));
			// marker behind the jump is never written
			emit(enc_rjmp(12'd1));
			emit(enc_out(6'd3, 5'd20));
		end
		emit(enc_rjmp(12'hfff));
		finish_program();
	endtask

	initial begin
		seed = 32'he8d5_c0c5;
		reset = 1'b1;
		cdata = 16'h0000;
		reset_prev = 1'b0;
		out_pending = 1'b0;
		writes_seen = 0;
		test_name = "reset";
		ldi_out_program();
		alu_program();
		wide_program();
		branch_program();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== risc8_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module risc8_core (
	input  logic                   clk,
	input  logic                   reset,
	output risc8_pkg::word_t       pc,
	input  risc8_pkg::word_t       cdata,
	output risc8_pkg::data_addr_t  data_addr,
	output logic                   data_wen,
	output risc8_pkg::byte_t       data_write
);
	// register file read selects and data
	risc8_pkg::reg_sel_t sel_a;
	risc8_pkg::reg_sel_t sel_b;
	risc8_pkg::byte_t rd_a;
	risc8_pkg::byte_t rd_b;

	// stage two controls
	risc8_pkg::alu_op_t alu_op;
	logic use_carry;
	logic use_const;
	risc8_pkg::byte_t const_value;
	logic wr_en;
	risc8_pkg::reg_sel_t wr_sel;
	logic out_en;
	risc8_pkg::data_addr_t out_addr;

	// write back and flags for the branch test
	risc8_pkg::byte_t wr_data;
	risc8_pkg::byte_t next_sreg;

	risc8_decode decode (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.next_sreg(next_sreg),
		.pc(pc),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.alu_op(alu_op),
		.use_carry(use_carry),
		.use_const(use_const),
		.wr_en(wr_en),
		.out_en(out_en),
		.const_value(const_value),
		.wr_sel(wr_sel),
		.out_addr(out_addr)
	);

	risc8_regfile regfile (
		.clk(clk),
		.reset(reset),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data)
	);

	risc8_execute execute (
		.clk(clk),
		.reset(reset),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.alu_op(alu_op),
		.use_carry(use_carry),
		.use_const(use_const),
		.const_value(const_value),
		.out_en(out_en),
		.out_addr(out_addr),
		.wr_data(wr_data),
		.next_sreg(next_sreg),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);

endmodule

`default_nettype wire

// ==== risc8_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module risc8_execute (
	input  logic                   clk,
	input  logic                   reset,
	input  risc8_pkg::byte_t       rd_a,
	input  risc8_pkg::byte_t       rd_b,
	input  risc8_pkg::alu_op_t     alu_op,
	input  logic                   use_carry,
	input  logic                   use_const,
	input  risc8_pkg::byte_t       const_value,
	input  logic                   out_en,
	input  risc8_pkg::data_addr_t  out_addr,
	output risc8_pkg::byte_t       wr_data,
	output risc8_pkg::byte_t       next_sreg,
	output risc8_pkg::data_addr_t  data_addr,
	output logic                   data_wen,
	output risc8_pkg::byte_t       data_write
);
	risc8_pkg::byte_t sreg;
	risc8_pkg::byte_t operand_b;
	risc8_pkg::byte_t alu_result;
	logic alu_carry;
	logic alu_zero;
	// INC and DEC arrive as add with a constant
	logic keep_c;
	logic keep_z;

	// immediate or Rr
	assign operand_b = use_const ? const_value : rd_b;

	risc8_alu alu (
		.op(alu_op),
		.a(rd_a),
		.b(operand_b),
		.carry_in(sreg[risc8_pkg::SREG_C]),
		.use_carry(use_carry),
		.result(alu_result),
		.carry_out(alu_carry),
		.zero_out(alu_zero)
	);

	assign wr_data = alu_result;

	assign keep_c = (alu_op == risc8_pkg::ALU_ADD) && use_const;
	assign keep_z = (alu_op == risc8_pkg::ALU_MOVE);

	// flags after this instruction, also seen by branch decode
	always_comb begin
		next_sreg = '0;
		next_sreg[risc8_pkg::SREG_C] = keep_c ? sreg[risc8_pkg::SREG_C] : alu_carry;
		if (keep_z)
			next_sreg[risc8_pkg::SREG_Z] = sreg[risc8_pkg::SREG_Z];
		else if (use_carry)
			// multi-byte compare, Z stays clear once any byte differed
			next_sreg[risc8_pkg::SREG_Z] = alu_zero & sreg[risc8_pkg::SREG_Z];
		else
			next_sreg[risc8_pkg::SREG_Z] = alu_zero;
	end

	always_ff @(posedge clk) begin
		if (reset)
			sreg <= '0;
		else
			sreg <= next_sreg;
	end

	// OUT writes Rd in the cycle after decode
	assign data_wen = out_en;
	assign data_write = out_en ? rd_a : '0;
	assign data_addr = out_en ? out_addr : '0;

	// the reset bubble never reaches the write port
	assert property (@(posedge clk) reset |=> !data_wen);

endmodule

`default_nettype wire

// ==== risc8_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module risc8_decode (
	input  logic                   clk,
	input  logic                   reset,
	input  risc8_pkg::word_t       cdata,
	input  risc8_pkg::byte_t       next_sreg,
	output risc8_pkg::word_t       pc,
	output risc8_pkg::reg_sel_t    sel_a,
	output risc8_pkg::reg_sel_t    sel_b,
	output risc8_pkg::alu_op_t     alu_op,
	output logic                   use_carry,
	output logic                   use_const,
	output logic                   wr_en,
	output logic                   out_en,
	output risc8_pkg::byte_t       const_value,
	output risc8_pkg::reg_sel_t    wr_sel,
	output risc8_pkg::data_addr_t  out_addr
);
	// address of the opcode now on cdata
	risc8_pkg::word_t reg_pc;
	risc8_pkg::word_t next_pc;
	// low during the bubble right after reset
	logic fetch_valid;

	// opcode fields
	risc8_pkg::reg_sel_t op_rd;
	risc8_pkg::reg_sel_t op_rr;
	risc8_pkg::reg_sel_t op_rdi;
	risc8_pkg::byte_t op_k;
	risc8_pkg::io_addr_t op_io;
	risc8_pkg::word_t simm12;
	risc8_pkg::word_t simm7;
	logic [2:0] op_bit;
	// set for BRBC, clear for BRBS
	logic op_clear;

	// stage two controls before the pipeline register
	risc8_pkg::alu_op_t dec_alu_op;
	logic dec_use_carry;
	logic dec_use_const;
	risc8_pkg::byte_t dec_const;
	logic dec_wr_en;
	risc8_pkg::reg_sel_t dec_wr_sel;
	logic dec_out_en;

	assign op_rd = cdata[8:4];
	assign op_rr = {cdata[9], cdata[3:0]};
	assign op_rdi = {risc8_pkg::HIGH_REG_BIT, cdata[7:4]};
	assign op_k = {cdata[11:8], cdata[3:0]};
	assign op_io = {cdata[10:9], cdata[3:0]};
	assign simm12 = {{4{cdata[11]}}, cdata[11:0]};
	assign simm7 = {{9{cdata[9]}}, cdata[9:3]};
	assign op_bit = cdata[2:0];
	assign op_clear = cdata[10];

	// program memory sees the next pc so it answers in time
	assign pc = next_pc;

	always_comb begin
		next_pc = reg_pc + 16'd1;
		sel_a = op_rd;
		sel_b = op_rr;
		// default is a nop, move without write keeps the flags
		dec_alu_op = risc8_pkg::ALU_MOVE;
		dec_use_carry = 1'b0;
		dec_use_const = 1'b0;
		dec_const = op_k;
		dec_wr_en = 1'b0;
		dec_wr_sel = op_rd;
		dec_out_en = 1'b0;

		if (!fetch_valid) begin
			// hold pc so the first word gets fetched again
			next_pc = reg_pc;
		end else begin
			// Rd bits are wildcards in every pattern
			casez (cdata)
			16'b0000_01??_????_????: begin
				// CPC
				dec_alu_op = risc8_pkg::ALU_SUB;
				dec_use_carry = 1'b1;
			end
			16'b0000_10??_????_????: begin
				// SBC
				dec_alu_op = risc8_pkg::ALU_SUB;
				dec_use_carry = 1'b1;
				dec_wr_en = 1'b1;
			end
			16'b0000_11??_????_????: begin
				dec_alu_op = risc8_pkg::ALU_ADD;
				dec_wr_en = 1'b1;
			end
			16'b0001_01??_????_????: begin
				// CP has flags only
				dec_alu_op = risc8_pkg::ALU_SUB;
			end
			16'b0001_10??_????_????: begin
				dec_alu_op = risc8_pkg::ALU_SUB;
				dec_wr_en = 1'b1;
			end
			16'b0001_11??_????_????: begin
				// ADC
				dec_alu_op = risc8_pkg::ALU_ADD;
				dec_use_carry = 1'b1;
				dec_wr_en = 1'b1;
			end
			16'b0010_00??_????_????: begin
				dec_alu_op = risc8_pkg::ALU_AND;
				dec_wr_en = 1'b1;
			end
			16'b0010_01??_????_????: begin
				dec_alu_op = risc8_pkg::ALU_EOR;
				dec_wr_en = 1'b1;
			end
			16'b0010_10??_????_????: begin
				dec_alu_op = risc8_pkg::ALU_OR;
				dec_wr_en = 1'b1;
			end
			16'b0010_11??_????_????: begin
				// MOV
				dec_wr_en = 1'b1;
			end
			16'b0011_????_????_????, 16'b0100_????_????_????, 16'b0101_????_????_????: begin
				// CPI, SBCI, SUBI on r16 to r31
				sel_a = op_rdi;
				dec_wr_sel = op_rdi;
				dec_alu_op = risc8_pkg::ALU_SUB;
				dec_use_const = 1'b1;
				dec_use_carry = (cdata[15:12] == 4'b0100);
				dec_wr_en = (cdata[15:12] != 4'b0011);
			end
			16'b0110_????_????_????: begin
				// ORI
				sel_a = op_rdi;
				dec_wr_sel = op_rdi;
				dec_alu_op = risc8_pkg::ALU_OR;
				dec_use_const = 1'b1;
				dec_wr_en = 1'b1;
			end
			16'b0111_????_????_????: begin
				// ANDI
				sel_a = op_rdi;
				dec_wr_sel = op_rdi;
				dec_alu_op = risc8_pkg::ALU_AND;
				dec_use_const = 1'b1;
				dec_wr_en = 1'b1;
			end
			16'b1001_010?_????_0000: begin
				// COM
				dec_alu_op = risc8_pkg::ALU_EOR;
				dec_use_const = 1'b1;
				dec_const = risc8_pkg::COM_MASK;
				dec_wr_en = 1'b1;
			end
			16'b1001_010?_????_0011, 16'b1001_010?_????_1010: begin
				// INC and DEC, both as add
				dec_alu_op = risc8_pkg::ALU_ADD;
				dec_use_const = 1'b1;
				dec_const = cdata[3] ? risc8_pkg::DEC_VALUE : risc8_pkg::INC_VALUE;
				dec_wr_en = 1'b1;
			end
			16'b1011_1???_????_????: begin
				// OUT reads Rd into operand a
				dec_out_en = 1'b1;
			end
			16'b1100_????_????_????: begin
				next_pc = reg_pc + 16'd1 + simm12;
			end
			16'b1110_????_????_????: begin
				// LDI
				dec_use_const = 1'b1;
				dec_wr_sel = op_rdi;
				dec_wr_en = 1'b1;
			end
			16'b1111_0???_????_????: begin
				// flags of the instruction now in stage two
				if (next_sreg[op_bit] != op_clear)
					next_pc = reg_pc + 16'd1 + simm7;
			end
			default: begin
				// unknown opcode runs as nop
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_pc <= risc8_pkg::RESET_PC;
			fetch_valid <= 1'b0;
			alu_op <= risc8_pkg::ALU_MOVE;
			use_carry <= 1'b0;
			use_const <= 1'b0;
			wr_en <= 1'b0;
			out_en <= 1'b0;
		end else begin
			reg_pc <= next_pc;
			fetch_valid <= 1'b1;
			alu_op <= dec_alu_op;
			use_carry <= dec_use_carry;
			use_const <= dec_use_const;
			wr_en <= dec_wr_en;
			out_en <= dec_out_en;
		end
	end

	// payload for stage two
	always_ff @(posedge clk) begin
		const_value <= dec_const;
		wr_sel <= dec_wr_sel;
		out_addr <= risc8_pkg::IO_BASE + risc8_pkg::data_addr_t'(op_io);
	end

	// an io write never also writes the register file
	assert property (@(posedge clk) disable iff (reset) !(out_en && wr_en));

endmodule

`default_nettype wire

// ==== risc8_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module risc8_regfile (
	input  logic                 clk,
	input  logic                 reset,
	input  risc8_pkg::reg_sel_t  sel_a,
	input  risc8_pkg::reg_sel_t  sel_b,
	output risc8_pkg::byte_t     rd_a,
	output risc8_pkg::byte_t     rd_b,
	input  logic                 wr_en,
	input  risc8_pkg::reg_sel_t  wr_sel,
	input  risc8_pkg::byte_t     wr_data
);
	// r0 to r31 in flops
	risc8_pkg::byte_t regs [32];

	// write at the end of the execute cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// reads are registered and arrive one cycle after the selects
	// a read of the register being written takes the new value
	always_ff @(posedge clk) begin
		if (wr_en && wr_sel == sel_a)
			rd_a <= wr_data;
		else
			rd_a <= regs[sel_a];

		if (wr_en && wr_sel == sel_b)
			rd_b <= wr_data;
		else
			rd_b <= regs[sel_b];
	end

endmodule

`default_nettype wire

// ==== risc8_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module risc8_alu (
	input  risc8_pkg::alu_op_t  op,
	input  risc8_pkg::byte_t    a,
	input  risc8_pkg::byte_t    b,
	input  logic                carry_in,
	input  logic                use_carry,
	output risc8_pkg::byte_t    result,
	output logic                carry_out,
	output logic                zero_out
);
	// carry only enters for ADC, SBC, SBCI and CPC
	logic cin;
	// ninth bit is the carry or the borrow
	logic [8:0] sum;
	logic [8:0] diff;

	assign cin = use_carry & carry_in;

	assign sum = {1'b0, a} + {1'b0, b} + {8'd0, cin};

	// wraps negative when b plus carry exceeds a
	assign diff = {1'b0, a} - {1'b0, b} - {8'd0, cin};

	always_comb begin
		// logic ops and move keep the carry
		result = b;
		carry_out = carry_in;

		case (op)
		risc8_pkg::ALU_ADD: begin
			result = sum[7:0];
			carry_out = sum[8];
		end
		risc8_pkg::ALU_SUB: begin
			result = diff[7:0];
			// C is the borrow
			carry_out = diff[8];
		end
		risc8_pkg::ALU_AND: begin
			result = a & b;
		end
		risc8_pkg::ALU_OR: begin
			result = a | b;
		end
		risc8_pkg::ALU_EOR: begin
			result = a ^ b;
		end
		risc8_pkg::ALU_MOVE: begin
			// LDI and MOV
			result = b;
		end
		default: begin
			result = b;
		end
		endcase
	end

	// plain zero test
	// chaining with the old Z happens with the status register
	assign zero_out = (result == '0);

endmodule

`default_nettype wire

// ==== risc8_pkg.sv ====
`default_nettype none

package risc8_pkg;

	// program word, also used for program addresses
	typedef logic [15:0] word_t;

	// register and data byte
	typedef logic [7:0] byte_t;

	// index into the 32 entry register file
	typedef logic [4:0] reg_sel_t;

	// 6-bit io space address carried in the OUT opcode
	typedef logic [5:0] io_addr_t;

	// data space address on the external write port
	typedef logic [15:0] data_addr_t;

	// alu operations
	// move passes operand b through and leaves the flags alone
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_MOVE
	} alu_op_t;

	// io address 0 maps to data address 0x20
	localparam data_addr_t IO_BASE = 16'h0020;

	// status register bit positions
	// only C and Z are kept, the other bits read as zero
	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;

	// first fetch address after reset
	localparam word_t RESET_PC = 16'h0000;

	// COM is an eor with all ones
	localparam byte_t COM_MASK = 8'hff;

	// INC adds one
	localparam byte_t INC_VALUE = 8'h01;

	// DEC adds all ones
	// an add with a constant then only comes from INC or DEC,
	// which is how stage two knows to keep C
	localparam byte_t DEC_VALUE = 8'hff;

	// high register index for the immediate forms, r16 to r31
	localparam logic HIGH_REG_BIT = 1'b1;

endpackage

`default_nettype wire
